// ==== ex_pkg.sv ====
package ex_pkg;

    localparam int data_width     = 32;                        // Operand and result width
    localparam int reg_addr_width = 5;                         // Register file address
    localparam int shamt_width    = 5;                         // Low bits of src1 used as shift
    localparam int op_width       = 8;                         // Function code width
    localparam int count_width    = $clog2(data_width + 1);    // Holds 0 to data_width

    // Function codes of the execute unit
    typedef enum logic [op_width-1:0] {
        op_or   = 8'h25,
        op_and  = 8'h24,
        op_xor  = 8'h26,
        op_nor  = 8'h27,
        op_srl  = 8'h02,
        op_sra  = 8'h03,
        op_sll  = 8'h7c,
        op_slt  = 8'h2a,
        op_sltu = 8'h2b,
        op_add  = 8'h20,
        op_addu = 8'h21,
        op_sub  = 8'h22,
        op_subu = 8'h23,
        op_clz  = 8'hb0,
        op_clo  = 8'hb1
    } op_t;

    // Operation as issued into the stage
    // The code is a plain vector so unused codes can still be carried
    typedef struct packed {
        logic [op_width-1:0]       op;                          // Function code
        logic [data_width-1:0]     src1;                        // Source 1, also shift amount
        logic [data_width-1:0]     src2;                        // Source 2
        logic [reg_addr_width-1:0] wr_addr;                     // Destination register
        logic                      wr_en;                       // Write request
    } issue_t;

    // Operation leaving the stage
    typedef struct packed {
        logic [reg_addr_width-1:0] wr_addr;                     // Destination register
        logic [data_width-1:0]     data;                        // Result word
        logic                      wr_en;                       // Final write enable
    } result_t;

endpackage

// ==== ex_stage_reg.sv ====
`timescale 1ns/1ps

module ex_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;                                             // Register holds an entry
    payload_t data_q;                                           // Stored payload

    // Accept when empty or when the current entry leaves this cycle
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;                                   // Refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

    // Held entry must not change until the consumer takes it
    hold_stable_chk: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("stage register changed under back-pressure");

    reset_empty_chk: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("stage register valid after reset");

endmodule

// ==== ex_count_lead.sv ====
`timescale 1ns/1ps

module ex_count_lead (
    input  logic [ex_pkg::data_width-1:0]  value,
    input  logic                           count_ones,
    output logic [ex_pkg::count_width-1:0] count
);

    logic [ex_pkg::data_width-1:0] scan;                        // Leading run turned into zeros

    // Counting ones is counting zeros of the inverted word
    assign scan = count_ones ? ~value : value;

    // Highest set bit of scan ends the run
    // Scanning upward lets the last hit win
    always_comb begin
        count = ex_pkg::count_width'(ex_pkg::data_width);       // Whole word is the run
        for (int i = 0; i < ex_pkg::data_width; i++) begin
            if (scan[i]) begin
                count = ex_pkg::count_width'(ex_pkg::data_width - 1 - i);
            end
        end
    end

endmodule

// ==== ex_alu.sv ====
`timescale 1ns/1ps

module ex_alu (
    input  logic            in_valid,
    input  ex_pkg::issue_t  in_data,
    output logic            out_valid,
    output ex_pkg::result_t out_data
);

    logic [ex_pkg::data_width-1:0]  src1;
    logic [ex_pkg::data_width-1:0]  src2;
    logic [ex_pkg::shamt_width-1:0] shamt;
    logic [ex_pkg::data_width-1:0]  sum;                        // src1 + src2
    logic [ex_pkg::data_width-1:0]  diff;                       // src1 - src2
    logic                           add_ovf;
    logic                           sub_ovf;
    logic [ex_pkg::count_width-1:0] lead_count;
    logic [ex_pkg::data_width-1:0]  result;
    logic                           wr_en;

    assign src1  = in_data.src1;
    assign src2  = in_data.src2;
    assign shamt = src1[ex_pkg::shamt_width-1:0];               // Shift amount from src1

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // Same-sign inputs giving an opposite-sign sum
    assign add_ovf = (src1[ex_pkg::data_width-1] == src2[ex_pkg::data_width-1]) &&
                     (sum[ex_pkg::data_width-1] != src1[ex_pkg::data_width-1]);
    // Differing signs with the result sign flipped away from src1
    assign sub_ovf = (src1[ex_pkg::data_width-1] != src2[ex_pkg::data_width-1]) &&
                     (diff[ex_pkg::data_width-1] != src1[ex_pkg::data_width-1]);

    ex_count_lead count_lead (
        .value      (src1),
        .count_ones (in_data.op == ex_pkg::op_clo),
        .count      (lead_count)
    );

    always_comb begin
        case (in_data.op)
            ex_pkg::op_or:   result = src1 | src2;
            ex_pkg::op_and:  result = src1 & src2;
            ex_pkg::op_xor:  result = src1 ^ src2;
            ex_pkg::op_nor:  result = ~(src1 | src2);
            ex_pkg::op_srl:  result = src2 >> shamt;
            ex_pkg::op_sra:  result = $signed(src2) >>> shamt;  // Sign fill
            ex_pkg::op_sll:  result = src2 << shamt;
            ex_pkg::op_slt:  result = ex_pkg::data_width'($signed(src1) < $signed(src2));
            ex_pkg::op_sltu: result = ex_pkg::data_width'(src1 < src2);
            ex_pkg::op_add,
            ex_pkg::op_addu: result = sum;
            ex_pkg::op_sub,
            ex_pkg::op_subu: result = diff;
            ex_pkg::op_clz,
            ex_pkg::op_clo:  result = ex_pkg::data_width'(lead_count);
            default:         result = '0;                       // Unused code
        endcase
    end

    // Only the trapping forms drop the write on overflow
    always_comb begin
        wr_en = in_data.wr_en;
        if (in_data.op == ex_pkg::op_add && add_ovf) begin
            wr_en = 1'b0;
        end
        if (in_data.op == ex_pkg::op_sub && sub_ovf) begin
            wr_en = 1'b0;
        end
    end

    assign out_valid        = in_valid;
    assign out_data.wr_addr = in_data.wr_addr;
    assign out_data.data    = result;
    assign out_data.wr_en   = wr_en;

    // Counter output must stay inside the word for any operand
    count_range_chk: assert final (!in_valid || lead_count <= ex_pkg::data_width)
        else $error("leading count out of range");

endmodule

// ==== ex_top.sv ====
`timescale 1ns/1ps

module ex_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic [ex_pkg::op_width-1:0]       in_op,
    input  logic [ex_pkg::data_width-1:0]     in_src1,
    input  logic [ex_pkg::data_width-1:0]     in_src2,
    input  logic [ex_pkg::reg_addr_width-1:0] in_wr_addr,
    input  logic                              in_wr_en,
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic [ex_pkg::reg_addr_width-1:0] out_wr_addr,
    output logic [ex_pkg::data_width-1:0]     out_data,
    output logic                              out_wr_en
);

    ex_pkg::issue_t  issue_in;                                  // Packed input operation
    ex_pkg::issue_t  issue_q;                                   // Registered operation
    logic            issue_valid;
    logic            alu_ready;                                 // Back-pressure from result_reg
    ex_pkg::result_t alu_result;
    logic            alu_valid;
    ex_pkg::result_t result_q;

    assign issue_in.op      = in_op;
    assign issue_in.src1    = in_src1;
    assign issue_in.src2    = in_src2;
    assign issue_in.wr_addr = in_wr_addr;
    assign issue_in.wr_en   = in_wr_en;

    ex_stage_reg #(.payload_t(ex_pkg::issue_t)) issue_reg (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (issue_in),
        .out_valid (issue_valid),
        .out_ready (alu_ready),
        .out_data  (issue_q)
    );

    ex_alu alu (
        .in_valid  (issue_valid),
        .in_data   (issue_q),
        .out_valid (alu_valid),
        .out_data  (alu_result)
    );

    ex_stage_reg #(.payload_t(ex_pkg::result_t)) result_reg (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (alu_valid),
        .in_ready  (alu_ready),
        .in_data   (alu_result),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (result_q)
    );

    assign out_wr_addr = result_q.wr_addr;
    assign out_data    = result_q.data;
    assign out_wr_en   = result_q.wr_en;

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period       = 8,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;                                          // Released on a clock edge
    end

endmodule

// ==== tb_ex_top.sv ====
`timescale 1ns/1ps

module tb_ex_top #(
    parameter int num_ops      = 2000,                          // Operations in the whole run
    parameter int stream_ops   = 200,                           // Leading run without stalls
    parameter int clk_period   = 8,
    parameter int reset_cycles = 5
);

    logic                              clk;
    logic                              reset;
    logic                              in_valid;
    logic                              in_ready;
    logic [ex_pkg::op_width-1:0]       in_op;
    logic [ex_pkg::data_width-1:0]     in_src1;
    logic [ex_pkg::data_width-1:0]     in_src2;
    logic [ex_pkg::reg_addr_width-1:0] in_wr_addr;
    logic                              in_wr_en;
    logic                              out_valid;
    logic                              out_ready;
    logic [ex_pkg::reg_addr_width-1:0] out_wr_addr;
    logic [ex_pkg::data_width-1:0]     out_data;
    logic                              out_wr_en;

    integer seed      = 32'hb667_0727;
    int     n_checks  = 0;
    int     n_errors  = 0;
    int     accepted  = 0;                                      // Input transfers so far
    int     delivered = 0;                                      // Output transfers so far
    int     cycle     = 0;

    // Scoreboard with one entry per operation in flight
    ex_pkg::result_t             exp_q[$];
    logic [ex_pkg::op_width-1:0] op_q[$];
    int                          cycle_q[$];                    // Edge of acceptance
    bit                          timed_q[$];                    // Accepted in the stall-free run

    ex_pkg::op_t kept_ops [15] = '{
        ex_pkg::op_or,  ex_pkg::op_and,  ex_pkg::op_xor,  ex_pkg::op_nor,
        ex_pkg::op_srl, ex_pkg::op_sra,  ex_pkg::op_sll,  ex_pkg::op_slt,
        ex_pkg::op_sltu, ex_pkg::op_add, ex_pkg::op_addu, ex_pkg::op_sub,
        ex_pkg::op_subu, ex_pkg::op_clz, ex_pkg::op_clo
    };

    tb_clock_gen #(.period(clk_period), .reset_cycles(reset_cycles)) clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    ex_top UUT (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_op       (in_op),
        .in_src1     (in_src1),
        .in_src2     (in_src2),
        .in_wr_addr  (in_wr_addr),
        .in_wr_en    (in_wr_en),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_wr_addr (out_wr_addr),
        .out_data    (out_data),
        .out_wr_en   (out_wr_en)
    );

    // Half of the operands are corner words
    function automatic logic [ex_pkg::data_width-1:0] random_operand();
        logic [2:0] pick;
        pick = $random(seed);
        case (pick)
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return 32'h8000_0000;
            3'd3:    return 32'h7fff_ffff;
            default: return $random(seed);
        endcase
    endfunction

    function automatic logic [ex_pkg::op_width-1:0] random_op();
        logic [3:0]  pick;
        logic [31:0] r;
        pick = $random(seed);
        r    = $random(seed);
        if (pick == 4'd0) begin
            return r[ex_pkg::op_width-1:0];                     // Mostly an unused code
        end
        return kept_ops[r % 15];
    endfunction

    // Length of the run of bit b from the top of the word
    function automatic int lead_run(input logic [31:0] word, input logic b);
        int n;
        n = 0;
        while (n < 32 && word[31 - n] == b) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic [31:0] model_result(input logic [7:0] op,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [63:0] ext;
        ext = {{32{b[31]}}, b};
        case (op)
            ex_pkg::op_or:   return a | b;
            ex_pkg::op_and:  return a & b;
            ex_pkg::op_xor:  return a ^ b;
            ex_pkg::op_nor:  return ~(a | b);
            ex_pkg::op_srl:  return b >> a[4:0];
            ex_pkg::op_sra:  return 32'(ext >> a[4:0]);         // Upper half supplies the sign
            ex_pkg::op_sll:  return b << a[4:0];
            ex_pkg::op_slt:  return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            ex_pkg::op_sltu: return {31'b0, a < b};
            ex_pkg::op_add,
            ex_pkg::op_addu: return a + b;
            ex_pkg::op_sub,
            ex_pkg::op_subu: return a + ~b + 32'd1;
            ex_pkg::op_clz:  return 32'(lead_run(a, 1'b0));
            ex_pkg::op_clo:  return 32'(lead_run(a, 1'b1));
            default:         return '0;
        endcase
    endfunction

    // Exact signed sum outside the 32-bit range means overflow
    function automatic logic model_wr_en(input logic [7:0] op, input logic [31:0] a,
                                         input logic [31:0] b, input logic we);
        longint s;
        if (op == ex_pkg::op_add) begin
            s = longint'($signed(a)) + longint'($signed(b));
        end else if (op == ex_pkg::op_sub) begin
            s = longint'($signed(a)) - longint'($signed(b));
        end else begin
            return we;
        end
        return (s > 64'sd2147483647 || s < -64'sd2147483648) ? 1'b0 : we;
    endfunction

    task automatic accept_op();
        ex_pkg::result_t exp;
        exp.wr_addr = in_wr_addr;
        exp.data    = model_result(in_op, in_src1, in_src2);
        exp.wr_en   = model_wr_en(in_op, in_src1, in_src2, in_wr_en);
        exp_q.push_back(exp);
        op_q.push_back(in_op);
        cycle_q.push_back(cycle);
        timed_q.push_back(accepted < stream_ops);
        accepted++;
    endtask

    task automatic check_output();
        ex_pkg::result_t             exp;
        logic [ex_pkg::op_width-1:0] op;
        int                          acc_cycle;
        bit                          timed;
        n_checks++;
        assert (exp_q.size() != 0) else begin
            n_errors++;
            $display("output transfer at %0t with no operation pending", $time);
        end
        if (exp_q.size() == 0) begin
            return;
        end
        exp       = exp_q.pop_front();
        op        = op_q.pop_front();
        acc_cycle = cycle_q.pop_front();
        timed     = timed_q.pop_front();
        delivered++;
        assert (out_data == exp.data) else begin
            n_errors++;
            $display("mismatch at %0t: op %h data %h expected %h",
                     $time, op, out_data, exp.data);
        end
        assert (out_wr_en == exp.wr_en) else begin
            n_errors++;
            $display("mismatch at %0t: op %h wr_en %b expected %b",
                     $time, op, out_wr_en, exp.wr_en);
        end
        assert (out_wr_addr == exp.wr_addr) else begin
            n_errors++;
            $display("mismatch at %0t: op %h wr_addr %0d expected %0d",
                     $time, op, out_wr_addr, exp.wr_addr);
        end
        assert (!timed || cycle - acc_cycle == 2) else begin
            n_errors++;
            $display("mismatch at %0t: latency %0d cycles expected 2",
                     $time, cycle - acc_cycle);
        end
    endtask

    task automatic drive_next();
        logic [31:0] r;
        r = $random(seed);
        // Held until the current operation is taken
        if (!in_valid || in_ready) begin
            if (accepted < num_ops && (accepted < stream_ops || r[1:0] != 2'b00)) begin
                in_valid   <= 1'b1;
                in_op      <= random_op();
                in_src1    <= random_operand();
                in_src2    <= random_operand();
                in_wr_addr <= r[ex_pkg::reg_addr_width+7:8];
                in_wr_en   <= r[4:2] != 3'b000;
            end else begin
                in_valid <= 1'b0;
            end
        end
        if (delivered < stream_ops) begin
            out_ready <= 1'b1;
        end else begin
            out_ready <= ($unsigned($random(seed)) % 10) < 7;   // About 70% ready
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            in_valid  <= 1'b0;
            out_ready <= 1'b0;
        end else begin
            cycle++;
            // Both stages full and nothing leaving
            if (exp_q.size() == 2 && !out_ready) begin
                n_checks++;
                assert (!in_ready) else begin
                    n_errors++;
                    $display("mismatch at %0t: in_ready high with both stages full", $time);
                end
            end
            if (out_valid && out_ready) begin
                check_output();
            end
            if (in_valid && in_ready) begin
                accept_op();
            end
            drive_next();
        end
    end

    initial begin
        in_valid   = 1'b0;
        in_op      = '0;
        in_src1    = '0;
        in_src2    = '0;
        in_wr_addr = '0;
        in_wr_en   = 1'b0;
        out_ready  = 1'b0;
        @(negedge reset);
        @(negedge clk);
        n_checks++;
        assert (!out_valid && in_ready) else begin
            n_errors++;
            $display("mismatch at %0t: out_valid %b in_ready %b after reset",
                     $time, out_valid, in_ready);
        end
        do begin
            @(negedge clk);
        end while (accepted < num_ops || exp_q.size() != 0);
        repeat (3) @(negedge clk);
        n_checks++;
        assert (!out_valid) else begin
            n_errors++;
            $display("output still valid at %0t after all operations were delivered", $time);
        end
        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Four cycles per operation is far above the worst random throughput
    initial begin
        #(4 * num_ops * clk_period + reset_cycles * clk_period);
        $display("timeout: the run did not deliver all operations in time");
        $display("checks %0d errors %0d", n_checks, n_errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== files.f ====
ex_pkg.sv
ex_stage_reg.sv
ex_count_lead.sv
ex_alu.sv
ex_top.sv
tb_clock_gen.sv
tb_ex_top.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - ex_pkg.sv
  - ex_stage_reg.sv
  - ex_count_lead.sv
  - ex_alu.sv
  - ex_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_ex_top.sv
